/* hw/fxp_pkg.sv */
// fixed-point two-term product unit, shared definitions
// widths, register map, bus types and the multiplier state encoding

package fxp_pkg;

  // ==================================================
  // widths and value types
  // ==================================================
  localparam int FXP_W = 16;          // operand width
  localparam int WB_ADR_W = 3;        // word address
  localparam int WB_DAT_W = 32;

  typedef logic signed [FXP_W-1:0] fxp_t;
  typedef logic signed [FXP_W:0]   wide_t;    // sum before clamp
  typedef logic [WB_ADR_W-1:0]     wb_adr_t;
  typedef logic [WB_DAT_W-1:0]     wb_data_t;

  localparam fxp_t FXP_MAX = {1'b0, {(FXP_W-1){1'b1}}};
  localparam fxp_t FXP_MIN = {1'b1, {(FXP_W-1){1'b0}}};

  // ==================================================
  // register map
  // ==================================================
  localparam wb_adr_t REG_A0     = 3'd0;
  localparam wb_adr_t REG_B0     = 3'd1;
  localparam wb_adr_t REG_A1     = 3'd2;
  localparam wb_adr_t REG_B1     = 3'd3;
  localparam wb_adr_t REG_CTRL   = 3'd4;  // [0] start, [1] subtract
  localparam wb_adr_t REG_STATUS = 3'd5;  // [0] busy, [1] done, [2] saturated
  localparam wb_adr_t REG_RESULT = 3'd6;

  typedef struct packed {
    fxp_t a;
    fxp_t b;
  } mult_req_t;

  typedef struct packed {
    fxp_t value;
    logic sat;
  } comb_res_t;

  typedef enum logic [1:0] {IDLE, CALC, DONE} mult_state_e;

endpackage

/* hw/fxp_iter_mult.sv */
// iterative signed fixed-point multiplier, one bit of b per clock
// valid/ready on the operand side and on the product side

`timescale 1ns/1ps

module fxp_iter_mult #(
  parameter int FRAC = 8  // fractional bits
) (
  input  logic              clk,
  input  logic              reset,
  input  fxp_pkg::mult_req_t req,
  input  logic              req_val,
  output logic              req_rdy,
  output fxp_pkg::fxp_t     prod,
  output logic              prod_val,
  input  logic              prod_rdy
);

  localparam int ACC_W = 2 * fxp_pkg::FXP_W;       // full product width
  localparam int CNT_W = $clog2(fxp_pkg::FXP_W);

  fxp_pkg::mult_state_e state;
  logic [CNT_W-1:0]    cnt;        // current bit of b
  logic signed [ACC_W-1:0] acc;
  logic signed [ACC_W-1:0] a_sh;   // a, weighted by the current bit
  logic signed [ACC_W-1:0] term;
  fxp_pkg::fxp_t       b_sh;
  logic                last_step;
  logic                accept;

  assign accept    = req_val && req_rdy;
  assign req_rdy   = (state == fxp_pkg::IDLE);
  assign prod_val  = (state == fxp_pkg::DONE);
  assign last_step = (cnt == CNT_W'(fxp_pkg::FXP_W - 1));

  // sign bit of b carries negative weight
  assign term = last_step ? -a_sh : a_sh;

  // drop FRAC bits, keep the low word (wraps)
  assign prod = acc[FRAC +: fxp_pkg::FXP_W];

  // ==================================================
  // control
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fxp_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        fxp_pkg::IDLE: begin
          if (req_val) begin
            state <= fxp_pkg::CALC;
            cnt   <= '0;
          end
        end
        fxp_pkg::CALC: begin
          cnt <= cnt + 1'b1;
          if (last_step) begin
            state <= fxp_pkg::DONE;
          end
        end
        fxp_pkg::DONE: begin
          if (prod_rdy) begin
            state <= fxp_pkg::IDLE;  // held until the combiner takes it
          end
        end
        default: state <= fxp_pkg::IDLE;
      endcase
    end
  end

  // ==================================================
  // shift-and-add datapath
  // ==================================================
  always_ff @(posedge clk) begin
    if (accept) begin
      acc  <= '0;
      a_sh <= {{fxp_pkg::FXP_W{req.a[fxp_pkg::FXP_W-1]}}, req.a};  // sign extend
      b_sh <= req.b;
    end else if (state == fxp_pkg::CALC) begin
      if (b_sh[0]) begin
        acc <= acc + term;
      end
      a_sh <= a_sh << 1;
      b_sh <= b_sh >> 1;  // next bit of b into position 0
    end
  end

endmodule

/* hw/fxp_pair_combiner.sv */
// joins the two product streams, adds or subtracts them
// and clamps the sum to the operand range

`timescale 1ns/1ps

module fxp_pair_combiner (
  input  logic               clk,
  input  logic               reset,
  input  fxp_pkg::fxp_t      prod0,
  input  logic               prod0_val,
  input  fxp_pkg::fxp_t      prod1,
  input  logic               prod1_val,
  output logic               prod_rdy,
  input  logic               subtract,
  output fxp_pkg::comb_res_t res,
  output logic               res_val
);

  fxp_pkg::wide_t sum;
  logic           both;
  logic           ovf;

  // consume only when both products are here
  assign both     = prod0_val && prod1_val;
  assign prod_rdy = both;

  assign sum = subtract ? fxp_pkg::wide_t'(prod0) - fxp_pkg::wide_t'(prod1)
                        : fxp_pkg::wide_t'(prod0) + fxp_pkg::wide_t'(prod1);

  // top two bits disagree when the sum leaves the 16-bit range
  assign ovf = sum[fxp_pkg::FXP_W] != sum[fxp_pkg::FXP_W-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      res_val <= 1'b0;
    end else begin
      res_val <= both;  // one-clock pulse
    end
  end

  always_ff @(posedge clk) begin
    if (both) begin
      if (ovf) begin
        res.value <= sum[fxp_pkg::FXP_W] ? fxp_pkg::FXP_MIN : fxp_pkg::FXP_MAX;
      end else begin
        res.value <= sum[fxp_pkg::FXP_W-1:0];
      end
      res.sat <= ovf;
    end
  end

endmodule

/* hw/wb_fxp_regs.sv */
// wishbone classic register block for the two-term product unit
// holds operands, control, status and result, and launches each job

`timescale 1ns/1ps

module wb_fxp_regs (
  input  logic               clk,
  input  logic               reset,
  input  logic               wb_cyc,
  input  logic               wb_stb,
  input  logic               wb_we,
  input  fxp_pkg::wb_adr_t   wb_adr,
  input  fxp_pkg::wb_data_t  wb_dat_w,
  output fxp_pkg::wb_data_t  wb_dat_r,
  output logic               wb_ack,
  output fxp_pkg::mult_req_t req0,
  output fxp_pkg::mult_req_t req1,
  output logic               req_val,
  input  logic               req_rdy0,
  input  logic               req_rdy1,
  output logic               subtract,
  input  fxp_pkg::comb_res_t res,
  input  logic               res_val
);

  fxp_pkg::fxp_t     a0, b0, a1, b1;  // software copies
  fxp_pkg::fxp_t     result;
  fxp_pkg::wb_data_t rd_data;
  logic ctrl_sub;
  logic busy, done, sat;
  logic req_seen;
  logic wr;
  logic start;

  function automatic fxp_pkg::wb_data_t sext(input fxp_pkg::fxp_t v);
    return {{(fxp_pkg::WB_DAT_W - fxp_pkg::FXP_W){v[fxp_pkg::FXP_W-1]}}, v};
  endfunction

  assign req_seen = wb_cyc && wb_stb && !wb_ack;  // new request, not yet acked
  assign wr       = req_seen && wb_we;
  assign start    = wr && (wb_adr == fxp_pkg::REG_CTRL) && wb_dat_w[0] && !busy;

  // ==================================================
  // read mux
  // ==================================================
  always_comb begin
    case (wb_adr)
      fxp_pkg::REG_A0:     rd_data = sext(a0);
      fxp_pkg::REG_B0:     rd_data = sext(b0);
      fxp_pkg::REG_A1:     rd_data = sext(a1);
      fxp_pkg::REG_B1:     rd_data = sext(b1);
      fxp_pkg::REG_CTRL:   rd_data = {{(fxp_pkg::WB_DAT_W-2){1'b0}}, ctrl_sub, 1'b0};
      fxp_pkg::REG_STATUS: rd_data = {{(fxp_pkg::WB_DAT_W-3){1'b0}}, sat, done, busy};
      fxp_pkg::REG_RESULT: rd_data = sext(result);
      default:             rd_data = '0;
    endcase
  end

  // operand registers, written even while busy
  always_ff @(posedge clk) begin
    if (wr) begin
      case (wb_adr)
        fxp_pkg::REG_A0: a0 <= wb_dat_w[fxp_pkg::FXP_W-1:0];
        fxp_pkg::REG_B0: b0 <= wb_dat_w[fxp_pkg::FXP_W-1:0];
        fxp_pkg::REG_A1: a1 <= wb_dat_w[fxp_pkg::FXP_W-1:0];
        fxp_pkg::REG_B1: b1 <= wb_dat_w[fxp_pkg::FXP_W-1:0];
        default: ;
      endcase
    end
    if (req_seen) begin
      wb_dat_r <= rd_data;
    end
  end

  // job snapshot, the running job never sees later writes
  always_ff @(posedge clk) begin
    if (start) begin
      req0 <= '{a: a0, b: b0};
      req1 <= '{a: a1, b: b1};
    end
  end

  // ==================================================
  // bus ack, job start and done tracking
  // ==================================================
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack   <= 1'b0;
      ctrl_sub <= 1'b0;
      subtract <= 1'b0;
      req_val  <= 1'b0;
      busy     <= 1'b0;
      done     <= 1'b0;
      sat      <= 1'b0;
      result   <= '0;
    end else begin
      wb_ack <= req_seen;  // single-clock ack
      if (wr && wb_adr == fxp_pkg::REG_CTRL) begin
        ctrl_sub <= wb_dat_w[1];
      end
      if (start) begin
        subtract <= wb_dat_w[1];  // level for the whole job
        req_val  <= 1'b1;
        busy     <= 1'b1;
        done     <= 1'b0;
        sat      <= 1'b0;
      end else if (req_val && req_rdy0 && req_rdy1) begin
        req_val <= 1'b0;  // both multipliers took it
      end
      if (res_val) begin
        result <= res.value;
        sat    <= res.sat;
        done   <= 1'b1;
        busy   <= 1'b0;
      end
    end
  end

endmodule

/* hw/fxp_dot2_top.sv */
// two-term fixed-point product unit, top level
// register block feeding two parallel multipliers and a combiner

`timescale 1ns/1ps

module fxp_dot2_top #(
  parameter int FRAC = 8  // fractional bits, 1 to 15
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  fxp_pkg::wb_adr_t  wb_adr,
  input  fxp_pkg::wb_data_t wb_dat_w,
  output fxp_pkg::wb_data_t wb_dat_r,
  output logic              wb_ack
);

  fxp_pkg::mult_req_t req0, req1;
  logic               req_val;
  logic               req_rdy0, req_rdy1;
  fxp_pkg::fxp_t      prod0, prod1;
  logic               prod0_val, prod1_val;
  logic               prod_rdy;   // shared, products leave together
  logic               subtract;
  fxp_pkg::comb_res_t res;
  logic               res_val;

  wb_fxp_regs u_regs (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .req0     (req0),
    .req1     (req1),
    .req_val  (req_val),
    .req_rdy0 (req_rdy0),
    .req_rdy1 (req_rdy1),
    .subtract (subtract),
    .res      (res),
    .res_val  (res_val)
  );

  // ==================================================
  // multipliers, A0*B0 and A1*B1
  // ==================================================
  fxp_iter_mult #(.FRAC(FRAC)) u_mult0 (
    .clk      (clk),
    .reset    (reset),
    .req      (req0),
    .req_val  (req_val),
    .req_rdy  (req_rdy0),
    .prod     (prod0),
    .prod_val (prod0_val),
    .prod_rdy (prod_rdy)
  );

  fxp_iter_mult #(.FRAC(FRAC)) u_mult1 (
    .clk      (clk),
    .reset    (reset),
    .req      (req1),
    .req_val  (req_val),
    .req_rdy  (req_rdy1),
    .prod     (prod1),
    .prod_val (prod1_val),
    .prod_rdy (prod_rdy)
  );

  fxp_pair_combiner u_comb (
    .clk       (clk),
    .reset     (reset),
    .prod0     (prod0),
    .prod0_val (prod0_val),
    .prod1     (prod1),
    .prod1_val (prod1_val),
    .prod_rdy  (prod_rdy),
    .subtract  (subtract),
    .res       (res),
    .res_val   (res_val)
  );

endmodule

/* tests/fxp_dot2_checker.sv */
// bus monitor and reference model for the two-term product unit
// snoops operand and start writes, checks STATUS and RESULT reads

`timescale 1ns/1ps

module fxp_dot2_checker #(
  parameter int FRAC = 8
) (
  input logic              clk,
  input logic              reset,
  input logic              wb_cyc,
  input logic              wb_stb,
  input logic              wb_we,
  input fxp_pkg::wb_adr_t  wb_adr,
  input fxp_pkg::wb_data_t wb_dat_w,
  input fxp_pkg::wb_data_t wb_dat_r,
  input logic              wb_ack
);

  fxp_pkg::fxp_t a0, b0, a1, b1;   // shadow operands
  fxp_pkg::fxp_t exp_val;
  fxp_pkg::fxp_t last_val;
  logic          exp_sat, last_sat, last_done;
  logic          pending;          // job started, done not yet read
  logic          busy_seen;
  int            err_count = 0;

  // full product, arithmetic shift by FRAC, low word kept
  function automatic fxp_pkg::fxp_t scaled_product(input fxp_pkg::fxp_t a,
                                                   input fxp_pkg::fxp_t b);
    longint full;
    full = longint'(a) * longint'(b);
    full = full >>> FRAC;
    return full[15:0];
  endfunction

  task automatic predict(input logic sub);
    longint s;
    s = longint'(scaled_product(a0, b0));
    if (sub) begin
      s = s - longint'(scaled_product(a1, b1));
    end else begin
      s = s + longint'(scaled_product(a1, b1));
    end
    if (s > 32767) begin
      exp_val = 16'h7fff;
      exp_sat = 1'b1;
    end else if (s < -32768) begin
      exp_val = 16'h8000;
      exp_sat = 1'b1;
    end else begin
      exp_val = s[15:0];
      exp_sat = 1'b0;
    end
  endtask

  task automatic compare(input string name, input fxp_pkg::wb_data_t exp_w,
                         input fxp_pkg::wb_data_t got_w);
    if (exp_w !== got_w) begin
      $display("error wb_dat_r %s exp %08h got %08h", name, exp_w, got_w);
      err_count++;
    end
  endtask

  // ==================================================
  // bus snooping, sampled mid-cycle while ack is high
  // ==================================================
  task automatic snoop_write();
    case (wb_adr)
      fxp_pkg::REG_A0: a0 = wb_dat_w[15:0];
      fxp_pkg::REG_B0: b0 = wb_dat_w[15:0];
      fxp_pkg::REG_A1: a1 = wb_dat_w[15:0];
      fxp_pkg::REG_B1: b1 = wb_dat_w[15:0];
      fxp_pkg::REG_CTRL: begin
        if (wb_dat_w[0] && !pending) begin  // start while busy is dropped
          predict(wb_dat_w[1]);
          pending   = 1'b1;
          busy_seen = 1'b0;
        end
      end
      default: ;
    endcase
  endtask

  task automatic check_read();
    case (wb_adr)
      fxp_pkg::REG_STATUS: begin
        if (pending && wb_dat_r[1]) begin
          compare("status", {29'b0, exp_sat, 2'b10}, wb_dat_r);
          if (!busy_seen) begin
            $display("job reported done without busy ever being read");
            err_count++;
          end
          pending   = 1'b0;
          last_done = 1'b1;
          last_val  = exp_val;
          last_sat  = exp_sat;
        end else if (pending) begin
          compare("status", 32'h1, wb_dat_r);  // busy only
          busy_seen = 1'b1;
        end else begin
          compare("status", {29'b0, last_sat, last_done, 1'b0}, wb_dat_r);
        end
      end
      fxp_pkg::REG_RESULT: compare("result", {{16{last_val[15]}}, last_val}, wb_dat_r);
      default: ;
    endcase
  endtask

  always @(negedge clk) begin
    if (reset) begin
      a0        = '0;
      b0        = '0;
      a1        = '0;
      b1        = '0;
      last_val  = '0;
      last_sat  = 1'b0;
      last_done = 1'b0;
      pending   = 1'b0;
      busy_seen = 1'b0;
    end else begin
      if (wb_ack && !(wb_cyc && wb_stb)) begin
        $display("ack seen with no bus request");
        err_count++;
      end
      if (wb_ack && wb_cyc && wb_stb) begin
        if (wb_we) begin
          snoop_write();
        end else begin
          check_read();
        end
      end
    end
  end

endmodule

/* tests/fxp_dot2_asserts.sv */
// handshake assertions for the two-term product unit
// bound into the top level

`timescale 1ns/1ps

module fxp_dot2_asserts (
  input logic clk,
  input logic reset,
  input logic wb_ack,
  input logic req_val,
  input logic req_rdy0,
  input logic req_rdy1,
  input logic prod0_val,
  input logic prod1_val,
  input logic prod_rdy,
  input logic res_val
);

  int fail_count = 0;

  ack_single: assert property (@(posedge clk) disable iff (reset) wb_ack |=> !wb_ack)
    else begin
      fail_count++;
      $error("wb_ack high two clocks running");
    end

  req_hold: assert property (@(posedge clk) disable iff (reset)
                             req_val && !(req_rdy0 && req_rdy1) |=> req_val)
    else begin
      fail_count++;
      $error("req_val dropped before both multipliers accepted");
    end

  prod0_hold: assert property (@(posedge clk) disable iff (reset)
                               prod0_val && !prod_rdy |=> prod0_val)
    else begin
      fail_count++;
      $error("prod0_val dropped without prod_rdy");
    end

  prod1_hold: assert property (@(posedge clk) disable iff (reset)
                               prod1_val && !prod_rdy |=> prod1_val)
    else begin
      fail_count++;
      $error("prod1_val dropped without prod_rdy");
    end

  res_pulse: assert property (@(posedge clk) disable iff (reset) res_val |=> !res_val)
    else begin
      fail_count++;
      $error("res_val longer than one clock");
    end

endmodule

bind fxp_dot2_top fxp_dot2_asserts u_asserts (
  .clk       (clk),
  .reset     (reset),
  .wb_ack    (wb_ack),
  .req_val   (req_val),
  .req_rdy0  (req_rdy0),
  .req_rdy1  (req_rdy1),
  .prod0_val (prod0_val),
  .prod1_val (prod1_val),
  .prod_rdy  (prod_rdy),
  .res_val   (res_val)
);

/* tests/tb_fxp_dot2.sv */
// testbench for the two-term fixed-point product unit
// drives a table of jobs over wishbone and polls for completion

`timescale 1ns/1ps

module tb_fxp_dot2;

  localparam int FRAC        = 8;
  localparam int NUM_FIXED   = 8;
  localparam int NUM_RANDOM  = 20;
  localparam int NUM_ROWS    = NUM_FIXED + NUM_RANDOM;
  localparam int CYCLE_LIMIT = NUM_ROWS * 60 + 200;

  typedef struct packed {
    fxp_pkg::fxp_t a0;
    fxp_pkg::fxp_t b0;
    fxp_pkg::fxp_t a1;
    fxp_pkg::fxp_t b1;
    logic          sub;
    logic          restart;  // second start while busy
  } row_t;

  logic              clk;
  logic              reset;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  fxp_pkg::wb_adr_t  wb_adr;
  fxp_pkg::wb_data_t wb_dat_w;
  fxp_pkg::wb_data_t wb_dat_r;
  logic              wb_ack;
  row_t              rows [NUM_ROWS];
  int                cycles = 0;

  fxp_dot2_top #(.FRAC(FRAC)) u_dut (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  fxp_dot2_checker #(.FRAC(FRAC)) u_chk (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  // hang guard
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout, run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // ==================================================
  // wishbone master
  // ==================================================
  task automatic bus_cycle(input logic we, input fxp_pkg::wb_adr_t adr,
                           input fxp_pkg::wb_data_t data,
                           output fxp_pkg::wb_data_t rdata);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = data;
    @(negedge clk);
    while (!wb_ack) begin
      @(negedge clk);
    end
    rdata = wb_dat_r;
    @(posedge clk);  // ack sampled here, release after
    #1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic bus_write(input fxp_pkg::wb_adr_t adr, input fxp_pkg::wb_data_t data);
    fxp_pkg::wb_data_t unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic bus_read(input fxp_pkg::wb_adr_t adr, output fxp_pkg::wb_data_t data);
    bus_cycle(1'b0, adr, '0, data);
  endtask

  // ==================================================
  // stimulus table
  // ==================================================
  task automatic build_table();
    logic [31:0] s;
    s = 32'h896d;
    rows[0] = '{16'h0180, 16'hff00, 16'hfe80, 16'hfe00, 1'b0, 1'b0};  // neg times neg
    rows[1] = '{16'h0040, 16'h0020, 16'hffc0, 16'h0300, 1'b0, 1'b0};  // fractions
    rows[2] = '{16'h0200, 16'h0180, 16'h0100, 16'hff80, 1'b1, 1'b0};
    rows[3] = '{16'hff37, 16'h00c5, 16'h0123, 16'hfe11, 1'b1, 1'b0};
    rows[4] = '{16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff, 1'b0, 1'b0};  // products wrap
    rows[5] = '{16'h7fff, 16'h0100, 16'h7fff, 16'h0100, 1'b0, 1'b0};  // clamp high
    rows[6] = '{16'h8000, 16'h0100, 16'h7fff, 16'h0100, 1'b1, 1'b0};  // clamp low
    rows[7] = '{16'h0300, 16'h0280, 16'h0100, 16'hff00, 1'b0, 1'b1};
    for (int i = NUM_FIXED; i < NUM_ROWS; i++) begin
      s = lcg_next(s);
      rows[i].a0 = s[31:16];
      s = lcg_next(s);
      rows[i].b0 = s[31:16];
      s = lcg_next(s);
      rows[i].a1 = s[31:16];
      s = lcg_next(s);
      rows[i].b1 = s[31:16];
      s = lcg_next(s);
      rows[i].sub     = s[31];
      rows[i].restart = 1'b0;
    end
  endtask

  function automatic fxp_pkg::wb_data_t word(input fxp_pkg::fxp_t v);
    return {{16{v[15]}}, v};
  endfunction

  task automatic run_row(input row_t r);
    fxp_pkg::wb_data_t status;
    fxp_pkg::wb_data_t rdata;
    bus_write(fxp_pkg::REG_A0, word(r.a0));
    bus_write(fxp_pkg::REG_B0, word(r.b0));
    bus_write(fxp_pkg::REG_A1, word(r.a1));
    bus_write(fxp_pkg::REG_B1, word(r.b1));
    bus_write(fxp_pkg::REG_CTRL, {30'b0, r.sub, 1'b1});
    if (r.restart) begin
      // new operands and a second start, all inside the running job
      bus_write(fxp_pkg::REG_A0, word(r.a0 ^ 16'h5555));
      bus_write(fxp_pkg::REG_B1, word(r.b1 ^ 16'h0f0f));
      bus_write(fxp_pkg::REG_CTRL, {30'b0, !r.sub, 1'b1});
    end
    status = '0;
    while (!status[1]) begin
      bus_read(fxp_pkg::REG_STATUS, status);  // poll for done
    end
    bus_read(fxp_pkg::REG_RESULT, rdata);
  endtask

  initial begin
    fxp_pkg::wb_data_t rdata;
    int errors;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    reset    = 1'b1;
    build_table();
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;
    repeat (4) @(posedge clk);  // idle bus, no ack expected
    #1;
    bus_read(fxp_pkg::REG_STATUS, rdata);
    bus_read(fxp_pkg::REG_RESULT, rdata);
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(rows[i]);
    end
    errors = u_chk.err_count + u_dut.u_asserts.fail_count;
    $display("run complete, %0d check errors, %0d assertion failures",
             u_chk.err_count, u_dut.u_asserts.fail_count);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
hw/fxp_pkg.sv
hw/fxp_iter_mult.sv
hw/fxp_pair_combiner.sv
hw/wb_fxp_regs.sv
hw/fxp_dot2_top.sv
tests/fxp_dot2_checker.sv
tests/fxp_dot2_asserts.sv
tests/tb_fxp_dot2.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fxp_dot2 testbench with Verilator.
# Fails on a build error, a nonzero simulation status,
# or the fail message in the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_fxp_dot2

verilator --binary --timing --assert -Wno-fatal \
  -f vlog.f --top-module tb_fxp_dot2 -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
  echo "failure reported in $LOG"
  exit 1
fi

exit 0
